//--- rtl/alu_ops_pkg.sv
//--------------------------------------------------------------------------
// ALU stage shared types
// Packet and configuration layouts, op and controller encodings, FIFO sizes
//--------------------------------------------------------------------------
`default_nettype none

package alu_ops_pkg;

    //--------------------------------------------------------------------------
    // Field widths
    //--------------------------------------------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [15:0] addr_t;
    typedef logic [3:0]  node_id_t;
    typedef logic [1:0]  hops_t;
    typedef logic [15:0] count_t;

    //--------------------------------------------------------------------------
    // Packet layout
    //--------------------------------------------------------------------------
    typedef struct packed {
        node_id_t from;
        node_id_t to;
        hops_t    hops;
    } route_t;

    typedef struct packed {
        route_t route;
        addr_t  address;
    } packet_meta_t;

    typedef struct packed {
        packet_meta_t meta;
        data_t        data;
    } packet_t;

    //--------------------------------------------------------------------------
    // Operation select and run configuration
    //--------------------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_MUL  = 3'd3,
        ALU_XOR  = 3'd4,
        // Running sum over the run, operand ignored
        ALU_ACC  = 3'd5
    } alu_op_t;

    typedef struct packed {
        alu_op_t op;
        data_t   operand;
        route_t  route;
        count_t  count;
    } alu_config_t;

    // Run controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        PAUSE,
        DRAIN
    } ctrl_state_t;

    // Buffer sizing for both packet FIFOs
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_PROG_THRESH = 8;

endpackage : alu_ops_pkg

`default_nettype wire

//--- rtl/sync_fifo.sv
//--------------------------------------------------------------------------
// Synchronous FIFO
// Registered read data with a one-cycle valid pulse, programmable full flag
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic             do_write;
    logic             do_read;

    // Requests only take effect when there is room or data
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign empty     = (occupancy == '0);
    assign full      = (occupancy == CNT_W'(DEPTH));
    assign prog_full = (occupancy >= CNT_W'(PROG_THRESH));

    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_read) begin
            rd_data <= mem[rd_ptr];
        end
    end

    //--------------------------------------------------------------------------
    // Pointers, occupancy and read strobe
    //--------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= do_read;
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Upstream must respect the full flag
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(wr_en && full))
        else $error("sync_fifo: write while full");

    // Every valid pulse answers a read request one cycle earlier
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        rd_valid |-> $past(rd_en))
        else $error("sync_fifo: rd_valid without a read request");

endmodule : sync_fifo

`default_nettype wire

//--- rtl/alu_ops_kernel.sv
//--------------------------------------------------------------------------
// ALU kernel
// One registered result per valid data word, plus a per-run accumulator
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_ops_kernel (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               run_active,
    input  alu_ops_pkg::alu_op_t op,
    input  alu_ops_pkg::data_t   operand,
    input  logic               data_valid,
    input  alu_ops_pkg::data_t   data,
    output alu_ops_pkg::data_t   result
);

    import alu_ops_pkg::*;

    data_t acc;
    data_t acc_sum;
    data_t result_next;

    // Sum including the current word
    assign acc_sum = acc + data;

    always_comb begin
        case (op)
            ALU_ADD: result_next = data + operand;
            ALU_SUB: result_next = data - operand;
            ALU_MUL: result_next = data * operand;
            ALU_XOR: result_next = data ^ operand;
            ALU_ACC: result_next = acc_sum;
            default: result_next = data;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (data_valid) begin
            result <= result_next;
        end
    end

    // Accumulator is cleared between runs
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            acc <= '0;
        end else if (!run_active) begin
            acc <= '0;
        end else if (data_valid) begin
            acc <= acc_sum;
        end
    end

endmodule : alu_ops_kernel

`default_nettype wire

//--- rtl/alu_ops_control.sv
//--------------------------------------------------------------------------
// ALU run controller
// Accepts a configuration, pops input items and counts results to the end
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_ops_control (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   cfg_valid,
    input  alu_ops_pkg::alu_config_t cfg,
    input  logic                   in_empty,
    input  logic                   out_prog_full,
    input  logic                   result_push,
    output logic                   in_pop,
    output alu_ops_pkg::alu_op_t     op,
    output alu_ops_pkg::data_t       operand,
    output alu_ops_pkg::route_t      route,
    output logic                   run_active,
    output logic                   done
);

    import alu_ops_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    alu_config_t cfg_q;
    count_t      issued;
    count_t      pushed;

    assign op      = cfg_q.op;
    assign operand = cfg_q.operand;
    assign route   = cfg_q.route;

    assign done       = (state == IDLE);
    assign run_active = (state != IDLE);

    // Pop only with data available, items left and room downstream
    assign in_pop = (state == RUN) && !in_empty && (issued < cfg_q.count) && !out_prog_full;

    //--------------------------------------------------------------------------
    // State machine
    //--------------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cfg_valid) begin
                    state_next = LOAD;
                end
            end
            LOAD: state_next = RUN;
            RUN: begin
                if (issued == cfg_q.count) begin
                    state_next = DRAIN;
                end else if (out_prog_full) begin
                    state_next = PAUSE;
                end
            end
            PAUSE: begin
                if (!out_prog_full) begin
                    state_next = RUN;
                end
            end
            DRAIN: begin
                if (pushed == cfg_q.count) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state  <= IDLE;
            issued <= '0;
            pushed <= '0;
        end else begin
            state <= state_next;
            if (state == LOAD) begin
                issued <= '0;
                pushed <= '0;
            end else begin
                if (in_pop) begin
                    issued <= issued + 1'b1;
                end
                if (result_push) begin
                    pushed <= pushed + 1'b1;
                end
            end
        end
    end

    // Configuration captured on acceptance, held for the whole run
    always_ff @(posedge ap_clk) begin
        if (state == IDLE && cfg_valid) begin
            cfg_q <= cfg;
        end
    end

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        in_pop |-> (state == RUN))
        else $error("alu_ops_control: pop outside RUN");

    // Results come back through the FIFO, kernel and result stage
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (state != LOAD) |-> (pushed <= issued))
        else $error("alu_ops_control: more results than issued items");

endmodule : alu_ops_control

`default_nettype wire

//--- rtl/alu_ops_result_stage.sv
//--------------------------------------------------------------------------
// ALU result stage
// Realigns packet metadata with the kernel result and pushes the packet
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_ops_result_stage (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    item_valid,
    input  alu_ops_pkg::packet_meta_t item_meta,
    input  alu_ops_pkg::route_t       route,
    input  alu_ops_pkg::data_t        result,
    output logic                    push,
    output alu_ops_pkg::packet_t      packet
);

    import alu_ops_pkg::*;

    logic  item_valid_d;
    addr_t address_d;

    //--------------------------------------------------------------------------
    // Match kernel latency
    //--------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            item_valid_d <= 1'b0;
        end else begin
            item_valid_d <= item_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        address_d <= item_meta.address;
    end

    //--------------------------------------------------------------------------
    // Packet build and push
    //--------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push <= 1'b0;
        end else begin
            push <= item_valid_d;
        end
    end

    // Route comes from the configuration, address from the input item
    always_ff @(posedge ap_clk) begin
        if (item_valid_d) begin
            packet.meta.route   <= route;
            packet.meta.address <= address_d;
            packet.data         <= result;
        end
    end

endmodule : alu_ops_result_stage

`default_nettype wire

//--- rtl/alu_ops_generator.sv
//--------------------------------------------------------------------------
// ALU stage top level
// Input FIFO, run controller, kernel, result stage and output FIFO
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_ops_generator (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   cfg_valid,
    input  alu_ops_pkg::alu_config_t cfg,
    input  logic                   in_push,
    input  alu_ops_pkg::packet_t     in_packet,
    output logic                   in_prog_full,
    input  logic                   out_ready,
    output logic                   out_valid,
    output alu_ops_pkg::packet_t     out_packet,
    output logic                   done
);

    import alu_ops_pkg::*;

    // Input side
    packet_t item_packet;
    logic    item_valid;
    logic    in_empty;
    logic    in_pop;

    // Controller outputs
    alu_op_t op;
    data_t   operand;
    route_t  route;
    logic    run_active;

    // Result side
    data_t   result;
    logic    result_push;
    packet_t result_packet;
    logic    out_prog_full;

    //--------------------------------------------------------------------------
    // Input packet FIFO
    //--------------------------------------------------------------------------
    sync_fifo #(
        .WIDTH       ($bits(packet_t)),
        .DEPTH       (FIFO_DEPTH),
        .PROG_THRESH (FIFO_PROG_THRESH)
    ) u_in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (in_push),
        .wr_data          (in_packet),
        .rd_en            (in_pop),
        .rd_data          (item_packet),
        .rd_valid         (item_valid),
        .empty            (in_empty),
        .full             (),
        .prog_full        (in_prog_full)
    );

    alu_ops_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .in_empty         (in_empty),
        .out_prog_full    (out_prog_full),
        .result_push      (result_push),
        .in_pop           (in_pop),
        .op               (op),
        .operand          (operand),
        .route            (route),
        .run_active       (run_active),
        .done             (done)
    );

    alu_ops_kernel u_kernel (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .run_active       (run_active),
        .op               (op),
        .operand          (operand),
        .data_valid       (item_valid),
        .data             (item_packet.data),
        .result           (result)
    );

    alu_ops_result_stage u_result_stage (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .item_valid       (item_valid),
        .item_meta        (item_packet.meta),
        .route            (route),
        .result           (result),
        .push             (result_push),
        .packet           (result_packet)
    );

    //--------------------------------------------------------------------------
    // Output packet FIFO, drained by the consumer
    //--------------------------------------------------------------------------
    sync_fifo #(
        .WIDTH       ($bits(packet_t)),
        .DEPTH       (FIFO_DEPTH),
        .PROG_THRESH (FIFO_PROG_THRESH)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (result_push),
        .wr_data          (result_packet),
        .rd_en            (out_ready),
        .rd_data          (out_packet),
        .rd_valid         (out_valid),
        .empty            (),
        .full             (),
        .prog_full        (out_prog_full)
    );

endmodule : alu_ops_generator

`default_nettype wire

//--- sim/alu_ops_checker.sv
//--------------------------------------------------------------------------
// ALU stage checker
// Models each accepted run, queues expected packets and reports per test
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_ops_checker (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     cfg_valid,
    input  alu_ops_pkg::alu_config_t cfg,
    input  logic                     in_push,
    input  alu_ops_pkg::packet_t     in_packet,
    input  logic                     out_valid,
    input  alu_ops_pkg::packet_t     out_packet,
    input  logic                     done
);

    import alu_ops_pkg::*;

    packet_t     expected_q[$];
    alu_config_t model_cfg;
    data_t       model_acc;
    string       test_name       = "reset";
    int          test_errors     = 0;
    int          test_checks     = 0;
    int          error_count     = 0;
    int          check_count     = 0;
    int          tests_run       = 0;
    int          tests_failed    = 0;
    logic        after_reset     = 1'b0;
    logic        expect_done_low = 1'b0;
    logic        prev_done       = 1'b1;

    // Expected data word of one item, straight from the op definitions
    function automatic data_t reference_result(alu_op_t op, data_t operand, data_t data,
                                               data_t acc);
        logic [63:0] product;
        product = 64'(data) * 64'(operand);
        case (op)
            ALU_ADD: return data + operand;
            ALU_SUB: return data - operand;
            ALU_MUL: return product[31:0];
            ALU_XOR: return data ^ operand;
            ALU_ACC: return acc + data;
            default: return data;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("error in %s: %s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic end_test();
        if (expected_q.size() != 0) begin
            report_failure($sformatf("%0d expected packets never arrived", expected_q.size()));
        end
        expected_q.delete();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%-7s %-16s packets %0d, errors %0d", (test_errors == 0) ? "ok" : "FAILED",
                 test_name, test_checks, test_errors);
    endtask

    task automatic final_report();
        $display("Tests %0d, failed %0d, packets checked %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
    endtask

    //--------------------------------------------------------------------------
    // Port monitor, sampled on the rising edge
    //--------------------------------------------------------------------------
    always @(posedge ap_clk) begin
        packet_t expected;
        if (areset_generator) begin
            after_reset     = 1'b1;
            expect_done_low = 1'b0;
            prev_done       = 1'b1;
        end else begin
            if (after_reset && !done) begin
                report_failure("done was low right after reset");
            end
            after_reset = 1'b0;
            if (expect_done_low && done) begin
                report_failure("done stayed high after an accepted configuration");
            end
            expect_done_low = 1'b0;

            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    report_failure($sformatf("unexpected extra packet %h", out_packet));
                end else begin
                    expected = expected_q.pop_front();
                    check_count++;
                    test_checks++;
                    if (out_packet !== expected) begin
                        $display("mismatch in %s: expected %h, actual %h",
                                 test_name, expected, out_packet);
                        test_errors++;
                        error_count++;
                    end
                end
            end

            // Whatever is still owed at done must fit in the output FIFO
            if (done && !prev_done && expected_q.size() > FIFO_DEPTH) begin
                report_failure($sformatf("done rose with %0d results not yet produced",
                                         expected_q.size()));
            end

            // Only a pulse while done is high starts a run
            if (cfg_valid && done) begin
                model_cfg       = cfg;
                model_acc       = '0;
                expect_done_low = 1'b1;
            end

            if (in_push) begin
                expected.meta.route   = model_cfg.route;
                expected.meta.address = in_packet.meta.address;
                expected.data         = reference_result(model_cfg.op, model_cfg.operand,
                                                         in_packet.data, model_acc);
                model_acc = model_acc + in_packet.data;
                expected_q.push_back(expected);
            end
            prev_done = done;
        end
    end

endmodule : alu_ops_checker

`default_nettype wire

//--- sim/alu_ops_tb.sv
//--------------------------------------------------------------------------
// ALU stage testbench
// Runs each op, accumulate, back-pressure and ignored-config scenarios
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_ops_tb;

    import alu_ops_pkg::*;

    localparam int OP_ITEMS       = 20;
    localparam int ACC_ITEMS      = 12;
    localparam int BP_ITEMS       = 30;
    localparam int IGN_ITEMS      = 20;
    localparam int TOTAL_ITEMS    = 5 * OP_ITEMS + 2 * ACC_ITEMS + BP_ITEMS + IGN_ITEMS;
    localparam int TIMEOUT_CYCLES = TOTAL_ITEMS * 40 + 2000;
    localparam int DRAIN_LIMIT    = FIFO_DEPTH + 2;
    localparam int HOLD_LIMIT     = 200;

    logic        ap_clk;
    logic        areset_generator;
    logic        cfg_valid;
    alu_config_t cfg;
    logic        in_push;
    packet_t     in_packet;
    logic        in_prog_full;
    logic        out_ready;
    logic        out_valid;
    packet_t     out_packet;
    logic        done;
    logic [31:0] data_seed;
    logic [31:0] stall_seed;
    alu_op_t     op_list [5];

    alu_ops_generator UUT (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .in_push          (in_push),
        .in_packet        (in_packet),
        .in_prog_full     (in_prog_full),
        .out_ready        (out_ready),
        .out_valid        (out_valid),
        .out_packet       (out_packet),
        .done             (done)
    );

    alu_ops_checker u_checker (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .in_push          (in_push),
        .in_packet        (in_packet),
        .out_valid        (out_valid),
        .out_packet       (out_packet),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function logic [31:0] next_data();
        data_seed = lcg_step(data_seed);
        return data_seed;
    endfunction

    task automatic finish_run(input logic timed_out);
        u_checker.final_report();
        if (!timed_out && u_checker.error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    //--------------------------------------------------------------------------
    // Producer and consumer
    //--------------------------------------------------------------------------
    task automatic push_items(input int count, input logic inject_cfg,
                              input alu_config_t run_cfg);
        packet_t     item;
        alu_config_t stray_cfg;
        logic [31:0] word;
        int          sent;
        sent             = 0;
        stray_cfg        = run_cfg;
        stray_cfg.op     = (run_cfg.op == ALU_XOR) ? ALU_ADD : ALU_XOR;
        stray_cfg.operand = ~run_cfg.operand;
        while (sent < count) begin
            @(posedge ap_clk);
            in_push   <= 1'b0;
            cfg_valid <= 1'b0;
            if (!in_prog_full) begin
                word                = next_data();
                item.meta.route     = word[9:0];
                item.meta.address   = word[31:16];
                item.data           = next_data();
                in_packet <= item;
                in_push   <= 1'b1;
                sent++;
                // Mid-run configuration that the DUT must ignore
                if (inject_cfg && sent == 5) begin
                    cfg       <= stray_cfg;
                    cfg_valid <= 1'b1;
                end
            end
        end
        @(posedge ap_clk);
        in_push   <= 1'b0;
        cfg_valid <= 1'b0;
    endtask

    task automatic consume_items(input int count, input logic hold_low);
        int received;
        int waited;
        int after_done;
        int drain_limit;
        received    = 0;
        waited      = 0;
        after_done  = 0;
        drain_limit = DRAIN_LIMIT;
        if (hold_low) begin
            while (!in_prog_full && waited < HOLD_LIMIT) begin
                @(posedge ap_clk);
                waited++;
                if (out_valid) begin
                    received++;
                    u_checker.report_failure("packet delivered while out_ready was low");
                end
            end
            if (!in_prog_full) begin
                u_checker.report_failure("in_prog_full never rose with the output held");
            end
        end
        while (received < count && after_done < drain_limit) begin
            @(posedge ap_clk);
            if (out_valid) begin
                received++;
            end
            if (done) begin
                // All owed packets sit in the output FIFO and leave back to back
                if (after_done == 0) begin
                    drain_limit = count - received + 2;
                end
                after_done++;
                out_ready <= 1'b1;
            end else begin
                stall_seed = lcg_step(stall_seed);
                out_ready <= (stall_seed[17:16] != 2'b00);
            end
        end
        if (received < count) begin
            u_checker.report_failure($sformatf("only %0d of %0d packets arrived after done",
                                               received, count));
        end
        out_ready <= 1'b1;
    endtask

    task automatic run_test(input string name, input alu_op_t op, input int count,
                            input logic hold_low, input logic inject_cfg);
        alu_config_t run_cfg;
        logic [31:0] word;
        @(negedge ap_clk);
        u_checker.start_test(name);
        word            = next_data();
        run_cfg.op      = op;
        run_cfg.operand = next_data();
        run_cfg.route   = word[9:0];
        run_cfg.count   = count_t'(count);
        @(posedge ap_clk);
        while (!done) begin
            @(posedge ap_clk);
        end
        cfg       <= run_cfg;
        cfg_valid <= 1'b1;
        if (hold_low) begin
            out_ready <= 1'b0;
        end
        @(posedge ap_clk);
        cfg_valid <= 1'b0;
        fork
            push_items(count, inject_cfg, run_cfg);
            consume_items(count, hold_low);
        join
        // A few idle cycles expose any packet beyond the count
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        if (!done) begin
            u_checker.report_failure("done did not return high after the run");
        end
        u_checker.end_test();
    endtask

    //--------------------------------------------------------------------------
    // Test sequence
    //--------------------------------------------------------------------------
    initial begin
        data_seed        = 32'd67;
        stall_seed       = lcg_step(32'd67);
        op_list          = '{ALU_PASS, ALU_ADD, ALU_SUB, ALU_MUL, ALU_XOR};
        areset_generator = 1'b1;
        cfg_valid        = 1'b0;
        cfg              = '0;
        in_push          = 1'b0;
        in_packet        = '0;
        out_ready        = 1'b0;
        repeat (10) @(posedge ap_clk);
        areset_generator <= 1'b0;
        foreach (op_list[i]) begin
            run_test($sformatf("op_%s", op_list[i].name()), op_list[i], OP_ITEMS, 1'b0, 1'b0);
        end
        run_test("accumulate_1", ALU_ACC, ACC_ITEMS, 1'b0, 1'b0);
        run_test("accumulate_2", ALU_ACC, ACC_ITEMS, 1'b0, 1'b0);
        run_test("back_pressure", ALU_ADD, BP_ITEMS, 1'b1, 1'b0);
        run_test("ignored_config", ALU_SUB, IGN_ITEMS, 1'b0, 1'b1);
        finish_run(1'b0);
    end

    // Watchdog sized from the total item count
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge ap_clk);
        u_checker.report_failure($sformatf("watchdog expired after %0d cycles",
                                           TIMEOUT_CYCLES));
        finish_run(1'b1);
    end

endmodule : alu_ops_tb

`default_nettype wire

//--- sim.f
rtl/alu_ops_pkg.sv
rtl/sync_fifo.sv
rtl/alu_ops_kernel.sv
rtl/alu_ops_control.sv
rtl/alu_ops_result_stage.sv
rtl/alu_ops_generator.sv
sim/alu_ops_checker.sv
sim/alu_ops_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ALU stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module alu_ops_tb \
    --Mdir obj_dir -o alu_ops_sim \
    -f sim.f

status=0
output=$(./obj_dir/alu_ops_sim) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
